//--- src/mem_bus_pkg.sv
`default_nettype none

package mem_bus_pkg;

    // burst memory port
    localparam int ADDR_W = 32;
    localparam int BEAT_W = 64;

    // cache line geometry
    localparam int LINE_W         = 256;
    localparam int BEATS_PER_LINE = LINE_W / BEAT_W;
    localparam int LINE_OFFSET_W  = 5;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [LINE_W-1:0] line_t;
    typedef logic [BEAT_W-1:0] beat_t;

endpackage

`default_nettype wire

//--- src/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

    localparam int INST_W  = 32;
    localparam int ORDER_W = 64;

    // first pc after reset
    localparam mem_bus_pkg::addr_t RESET_PC = 32'haaaaa000;

    localparam int QUEUE_DEPTH = 8;

    // word index inside a 32-byte line
    localparam int WORD_SEL_W = 3;

    // one fetched instruction, 128 bits
    typedef struct packed {
        logic [ORDER_W-1:0] order;
        mem_bus_pkg::addr_t pc;
        logic [INST_W-1:0]  inst;
    } fetch_entry_t;

endpackage

`default_nettype wire

//--- src/line_fill_if.sv
`timescale 1ns/1ps
`default_nettype none

interface line_fill_if;
    import mem_bus_pkg::*;

    // request side
    logic  req;
    addr_t line_addr;

    // response side
    logic  busy;
    logic  done;
    line_t line;
    addr_t done_addr;

    modport ctrl (
        output req,
        output line_addr,
        input  busy,
        input  done,
        input  line,
        input  done_addr
    );

    modport filler (
        input  req,
        input  line_addr,
        output busy,
        output done,
        output line,
        output done_addr
    );

endinterface

`default_nettype wire

//--- src/line_filler.sv
`timescale 1ns/1ps
`default_nettype none

module line_filler (
    input  logic                clk,
    input  logic                rst,

    line_fill_if.filler         fill,

    output mem_bus_pkg::addr_t  bmem_addr_o,
    output logic                bmem_read_o,
    input  logic                bmem_ready_i,
    input  mem_bus_pkg::addr_t  bmem_raddr_i,
    input  mem_bus_pkg::beat_t  bmem_rdata_i,
    input  logic                bmem_rvalid_i
);
    import mem_bus_pkg::*;

    localparam int BEAT_CNT_W = $clog2(BEATS_PER_LINE);

    typedef enum logic [1:0] {
        IDLE,
        REQ,
        WAIT,
        DONE
    } state_t;

    state_t                 state;
    logic [BEAT_CNT_W-1:0]  beat_cnt;
    addr_t                  pend_addr;
    line_t                  line_q;
    logic                   beat_ok;
    logic                   last_beat;

    // only beats of the pending line count
    assign beat_ok = (state == WAIT) && bmem_rvalid_i
                     && (bmem_raddr_i[ADDR_W-1:LINE_OFFSET_W] == pend_addr[ADDR_W-1:LINE_OFFSET_W]);
    assign last_beat = (beat_cnt == BEAT_CNT_W'(BEATS_PER_LINE - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= IDLE;
            beat_cnt <= '0;
        end else begin
            case (state)
                IDLE: begin
                    beat_cnt <= '0;
                    if (fill.req) begin
                        state <= REQ;
                    end
                end
                REQ: begin
                    // held until memory takes it
                    if (bmem_ready_i) begin
                        state <= WAIT;
                    end
                end
                WAIT: begin
                    if (beat_ok) begin
                        beat_cnt <= beat_cnt + BEAT_CNT_W'(1);
                        if (last_beat) begin
                            state <= DONE;
                        end
                    end
                end
                DONE: begin
                    state <= IDLE;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && fill.req) begin
            pend_addr <= {fill.line_addr[ADDR_W-1:LINE_OFFSET_W], {LINE_OFFSET_W{1'b0}}};
        end
        if (beat_ok) begin
            line_q[beat_cnt*BEAT_W +: BEAT_W] <= bmem_rdata_i;
        end
    end

    assign bmem_addr_o = pend_addr;
    assign bmem_read_o = (state == REQ);

    assign fill.busy      = (state != IDLE);
    assign fill.done      = (state == DONE);
    assign fill.line      = line_q;
    assign fill.done_addr = {pend_addr[ADDR_W-1:LINE_OFFSET_W], {LINE_OFFSET_W{1'b0}}};

endmodule

`default_nettype wire

//--- src/fetch_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_ctrl (
    input  logic                    clk,
    input  logic                    rst,

    input  logic                    redirect_i,
    input  mem_bus_pkg::addr_t      redirect_pc_i,

    line_fill_if.ctrl               fill,

    input  logic                    q_full_i,
    output logic                    q_push_o,
    output fetch_pkg::fetch_entry_t q_entry_o
);
    import mem_bus_pkg::*;
    import fetch_pkg::*;

    localparam int TAG_W = ADDR_W - LINE_OFFSET_W;

    addr_t                  pc_q;
    logic [ORDER_W-1:0]     order_q;

    // one-line buffer
    line_t                  lb_line;
    logic [TAG_W-1:0]       lb_tag;
    logic                   lb_valid;

    logic [TAG_W-1:0]       pc_tag;
    logic [WORD_SEL_W-1:0]  word_sel;
    logic                   lb_hit;
    logic                   fill_hit;
    line_t                  src_line;

    assign pc_tag   = pc_q[ADDR_W-1:LINE_OFFSET_W];
    assign word_sel = pc_q[LINE_OFFSET_W-1:2];

    assign lb_hit   = lb_valid && (lb_tag == pc_tag);

    // a finishing fill serves the pc directly, bypassing the buffer
    assign fill_hit = fill.done && (fill.done_addr[ADDR_W-1:LINE_OFFSET_W] == pc_tag);

    always_comb begin
        if (fill_hit) begin
            src_line = fill.line;
        end else begin
            src_line = lb_line;
        end
    end

    assign q_push_o = !redirect_i && !q_full_i && (lb_hit || fill_hit);

    always_comb begin
        q_entry_o.order = order_q;
        q_entry_o.pc    = pc_q;
        q_entry_o.inst  = src_line[word_sel*INST_W +: INST_W];
    end

    // miss with an idle filler
    assign fill.req       = !redirect_i && !lb_hit && !fill_hit && !fill.busy;
    assign fill.line_addr = {pc_tag, {LINE_OFFSET_W{1'b0}}};

    always_ff @(posedge clk) begin
        if (rst) begin
            pc_q    <= RESET_PC;
            order_q <= '0;
        end else if (redirect_i) begin
            // order keeps running across redirects
            pc_q <= redirect_pc_i;
        end else if (q_push_o) begin
            pc_q    <= pc_q + ADDR_W'(4);
            order_q <= order_q + ORDER_W'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            lb_valid <= 1'b0;
        end else if (fill.done) begin
            lb_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill.done) begin
            lb_line <= fill.line;
            lb_tag  <= fill.done_addr[ADDR_W-1:LINE_OFFSET_W];
        end
    end

endmodule

`default_nettype wire

//--- src/inst_queue.sv
`timescale 1ns/1ps
`default_nettype none

module inst_queue #(
    parameter int DEPTH = fetch_pkg::QUEUE_DEPTH
) (
    input  logic                    clk,
    input  logic                    rst,

    input  logic                    flush_i,

    input  logic                    push_i,
    input  fetch_pkg::fetch_entry_t entry_i,
    output logic                    full_o,

    output logic                    valid_o,
    input  logic                    ready_i,
    output fetch_pkg::fetch_entry_t entry_o
);
    import fetch_pkg::*;

    localparam int PTR_W = $clog2(DEPTH);

    fetch_entry_t       mem [DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [PTR_W:0]     count;
    logic               do_push;
    logic               do_pop;

    assign full_o  = (count == (PTR_W + 1)'(DEPTH));
    assign valid_o = (count != '0);
    assign entry_o = mem[rd_ptr];

    assign do_push = push_i && !full_o;
    assign do_pop  = valid_o && ready_i;

    // pointers wrap on their own, depth is a power of two
    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + PTR_W'(1);
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + PTR_W'(1);
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + (PTR_W + 1)'(1);
                2'b01:   count <= count - (PTR_W + 1)'(1);
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_push && !flush_i) begin
            mem[wr_ptr] <= entry_i;
        end
    end

endmodule

`default_nettype wire

//--- src/fetch_top.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_top (
    input  logic                            clk,
    input  logic                            rst,

    // burst memory
    output mem_bus_pkg::addr_t              bmem_addr_o,
    output logic                            bmem_read_o,
    input  logic                            bmem_ready_i,
    input  mem_bus_pkg::addr_t              bmem_raddr_i,
    input  mem_bus_pkg::beat_t              bmem_rdata_i,
    input  logic                            bmem_rvalid_i,

    // branch redirect
    input  logic                            redirect_i,
    input  mem_bus_pkg::addr_t              redirect_pc_i,

    // fetched instructions
    output logic                            fetch_valid_o,
    input  logic                            fetch_ready_i,
    output mem_bus_pkg::addr_t              fetch_pc_o,
    output logic [fetch_pkg::INST_W-1:0]    fetch_inst_o,
    output logic [fetch_pkg::ORDER_W-1:0]   fetch_order_o
);
    import fetch_pkg::*;

    fetch_entry_t   q_entry;
    fetch_entry_t   head_entry;
    logic           q_push;
    logic           q_full;

    line_fill_if fill_bus ();

    line_filler u_line_filler (
        .clk            (clk),
        .rst            (rst),
        .fill           (fill_bus.filler),
        .bmem_addr_o    (bmem_addr_o),
        .bmem_read_o    (bmem_read_o),
        .bmem_ready_i   (bmem_ready_i),
        .bmem_raddr_i   (bmem_raddr_i),
        .bmem_rdata_i   (bmem_rdata_i),
        .bmem_rvalid_i  (bmem_rvalid_i)
    );

    fetch_ctrl u_fetch_ctrl (
        .clk            (clk),
        .rst            (rst),
        .redirect_i     (redirect_i),
        .redirect_pc_i  (redirect_pc_i),
        .fill           (fill_bus.ctrl),
        .q_full_i       (q_full),
        .q_push_o       (q_push),
        .q_entry_o      (q_entry)
    );

    // redirect also drains everything already fetched
    inst_queue #(
        .DEPTH          (QUEUE_DEPTH)
    ) u_inst_queue (
        .clk            (clk),
        .rst            (rst),
        .flush_i        (redirect_i),
        .push_i         (q_push),
        .entry_i        (q_entry),
        .full_o         (q_full),
        .valid_o        (fetch_valid_o),
        .ready_i        (fetch_ready_i),
        .entry_o        (head_entry)
    );

    assign fetch_pc_o    = head_entry.pc;
    assign fetch_inst_o  = head_entry.inst;
    assign fetch_order_o = head_entry.order;

endmodule

`default_nettype wire

//--- tests/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter real PERIOD_NS = 8.0
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2.0) clk_o = ~clk_o;
    end

endmodule

`default_nettype wire

//--- tests/bmem_model.sv
`timescale 1ns/1ps
`default_nettype none

module bmem_model (
    input  logic                clk_i,
    input  logic                rst_i,
    input  mem_bus_pkg::addr_t  addr_i,
    input  logic                read_i,
    output logic                ready_o,
    output mem_bus_pkg::addr_t  raddr_o,
    output mem_bus_pkg::beat_t  rdata_o,
    output logic                rvalid_o
);
    import mem_bus_pkg::*;

    integer seed = 7923;
    logic   busy;
    addr_t  base;
    int     delay;
    int     beat;

    // memory contents, word at A is A xor 5a5a5a5a
    function automatic logic [31:0] word_at(input addr_t a);
        return a ^ 32'h5a5a5a5a;
    endfunction

    always @(posedge clk_i) begin
        if (rst_i) begin
            ready_o  <= 1'b0;
            rvalid_o <= 1'b0;
            raddr_o  <= '0;
            rdata_o  <= '0;
            busy     <= 1'b0;
            base     <= '0;
            delay    <= 0;
            beat     <= 0;
        end else begin
            rvalid_o <= 1'b0;
            if (!busy) begin
                if (read_i && ready_o) begin
                    busy    <= 1'b1;
                    base    <= addr_i;
                    beat    <= 0;
                    delay   <= $random(seed) & 7;
                    ready_o <= 1'b0;
                end else begin
                    ready_o <= (($random(seed) & 3) != 0);
                end
            end else if (delay != 0) begin
                delay <= delay - 1;
            end else if (($random(seed) & 3) != 0) begin
                // beat k carries bytes 8k..8k+7, lower word in the low half
                rvalid_o <= 1'b1;
                raddr_o  <= base + 8 * beat;
                rdata_o  <= {word_at(base + 8 * beat + 4), word_at(base + 8 * beat)};
                beat     <= beat + 1;
                if (beat == 3) begin
                    busy <= 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- tests/fetch_tb.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_tb;
    import mem_bus_pkg::*;
    import fetch_pkg::*;

    localparam int NUM_ROWS = 6;
    localparam int ENTRY_TIMEOUT = 300;

    typedef struct {
        bit    do_redirect;
        addr_t target;
        int    count;
        bit    slow_ready;
    } row_t;

    logic clk, rst, redirect_i, fetch_ready_i;
    logic bmem_read_o, bmem_ready_i, bmem_rvalid_i, fetch_valid_o;
    addr_t bmem_addr_o, bmem_raddr_i, redirect_pc_i, fetch_pc_o;
    beat_t bmem_rdata_i;
    logic [INST_W-1:0] fetch_inst_o;
    logic [ORDER_W-1:0] fetch_order_o;

    row_t rows [NUM_ROWS];
    string row_name [NUM_ROWS];
    addr_t exp_pc;
    logic [ORDER_W-1:0] last_order;
    bit seen_any;
    int row_errors, passed, failed;

    bit read_waiting;
    addr_t waiting_addr;
    int bus_errors;

    tb_clock #(.PERIOD_NS(8.0)) clock0 (.clk_o(clk));

    bmem_model mem0 (
        .clk_i(clk), .rst_i(rst), .addr_i(bmem_addr_o), .read_i(bmem_read_o),
        .ready_o(bmem_ready_i), .raddr_o(bmem_raddr_i), .rdata_o(bmem_rdata_i),
        .rvalid_o(bmem_rvalid_i)
    );

    fetch_top dut0 (
        .clk(clk), .rst(rst),
        .bmem_addr_o(bmem_addr_o), .bmem_read_o(bmem_read_o), .bmem_ready_i(bmem_ready_i),
        .bmem_raddr_i(bmem_raddr_i), .bmem_rdata_i(bmem_rdata_i),
        .bmem_rvalid_i(bmem_rvalid_i),
        .redirect_i(redirect_i), .redirect_pc_i(redirect_pc_i),
        .fetch_valid_o(fetch_valid_o), .fetch_ready_i(fetch_ready_i),
        .fetch_pc_o(fetch_pc_o), .fetch_inst_o(fetch_inst_o), .fetch_order_o(fetch_order_o)
    );

    // a burst read holds its line-aligned address until memory takes it
    always @(negedge clk) begin
        if (read_waiting) begin
            assert (bmem_read_o && bmem_addr_o == waiting_addr) else begin
                $display("error: %0t: burst read dropped or moved before accept", $time);
                bus_errors++;
            end
        end
        if (bmem_read_o) begin
            assert (bmem_addr_o[LINE_OFFSET_W-1:0] == '0) else begin
                $display("error: %0t: read address %h not line aligned", $time, bmem_addr_o);
                bus_errors++;
            end
        end
        read_waiting = bmem_read_o && !bmem_ready_i;
        waiting_addr = bmem_addr_o;
    end

    function automatic logic [INST_W-1:0] expected_inst(input addr_t pc);
        return pc ^ 32'h5a5a5a5a;
    endfunction

    // slow pattern drops ready every third cycle
    function automatic logic ready_for(input int cyc, input bit slow);
        return !(slow && (cyc % 3 == 2));
    endfunction

    task automatic apply_redirect(input addr_t target);
        @(posedge clk);
        redirect_i    <= 1'b1;
        redirect_pc_i <= target;
        fetch_ready_i <= 1'b0;
        @(posedge clk);
        redirect_i    <= 1'b0;
    endtask

    task automatic check_entry(input bit first_after_redirect);
        assert (fetch_pc_o == exp_pc) else begin
            $display("error: %0t: pc %h, expected %h", $time, fetch_pc_o, exp_pc);
            row_errors++;
        end
        assert (fetch_inst_o == expected_inst(exp_pc)) else begin
            $display("error: %0t: inst %h at pc %h, expected %h", $time, fetch_inst_o,
                     exp_pc, expected_inst(exp_pc));
            row_errors++;
        end
        if (!seen_any) begin
            assert (fetch_order_o == '0) else begin
                $display("error: %0t: first order %0d, expected 0", $time, fetch_order_o);
                row_errors++;
            end
        end else if (first_after_redirect) begin
            assert (fetch_order_o > last_order) else begin
                $display("error: %0t: order %0d not above %0d", $time, fetch_order_o,
                         last_order);
                row_errors++;
            end
        end else begin
            assert (fetch_order_o == last_order + 1) else begin
                $display("error: %0t: order %0d, expected %0d", $time, fetch_order_o,
                         last_order + 1);
                row_errors++;
            end
        end
        seen_any   = 1'b1;
        last_order = fetch_order_o;
        exp_pc     = exp_pc + 4;
    endtask

    task automatic collect_entries(input int count, input bit slow, input bit redirected);
        int got, cyc, waited;
        bit held, first;
        addr_t held_pc;
        logic [INST_W-1:0] held_inst;
        logic [ORDER_W-1:0] held_order;
        got = 0;
        cyc = 0;
        waited = 0;
        held = 1'b0;
        first = redirected;
        while (got < count) begin
            @(posedge clk);
            fetch_ready_i <= ready_for(cyc, slow);
            cyc++;
            @(negedge clk);
            if (held) begin
                assert (fetch_valid_o && fetch_pc_o == held_pc && fetch_inst_o == held_inst
                        && fetch_order_o == held_order) else begin
                    $display("error: %0t: head changed or dropped while ready was low", $time);
                    row_errors++;
                end
            end
            held       = fetch_valid_o && !fetch_ready_i;
            held_pc    = fetch_pc_o;
            held_inst  = fetch_inst_o;
            held_order = fetch_order_o;
            if (fetch_valid_o && fetch_ready_i) begin
                check_entry(first);
                first = 1'b0;
                got++;
                waited = 0;
            end else begin
                waited++;
                if (waited > ENTRY_TIMEOUT) begin
                    $display("timeout: no entry arrived within %0d cycles, %0d of %0d taken",
                             ENTRY_TIMEOUT, got, count);
                    row_errors++;
                    break;
                end
            end
        end
    endtask

    initial begin
        rows[0] = '{1'b0, 32'h0, 20, 1'b0};
        rows[1] = '{1'b0, 32'h0, 24, 1'b1};
        rows[2] = '{1'b1, 32'h0003_0100, 14, 1'b0};
        rows[3] = '{1'b1, 32'h0001_0040, 1, 1'b0};
        // target sits in the line just filled
        rows[4] = '{1'b1, 32'h0001_0048, 16, 1'b1};
        rows[5] = '{1'b1, 32'h0002_0fe8, 10, 1'b1};
        row_name = '{"sequential from reset", "back-pressure", "redirect to new line",
                     "redirect, single entry", "redirect within line", "redirect near line end"};

        rst <= 1'b1;
        redirect_i <= 1'b0;
        redirect_pc_i <= '0;
        fetch_ready_i <= 1'b0;
        exp_pc = RESET_PC;
        last_order = '0;
        seen_any = 1'b0;
        passed = 0;
        failed = 0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;

        for (int i = 0; i < NUM_ROWS; i++) begin
            row_errors = 0;
            if (rows[i].do_redirect) begin
                apply_redirect(rows[i].target);
                exp_pc = rows[i].target;
            end
            collect_entries(rows[i].count, rows[i].slow_ready, rows[i].do_redirect);
            if (row_errors == 0) begin
                passed++;
            end else begin
                failed++;
            end
            $display("test %0d %s: %0d errors", i + 1, row_name[i], row_errors);
        end

        $display("tests run %0d, passed %0d, failed %0d, bus errors %0d", NUM_ROWS, passed,
                 failed, bus_errors);
        if (failed == 0 && bus_errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
src/mem_bus_pkg.sv
src/fetch_pkg.sv
src/line_fill_if.sv
src/line_filler.sv
src/fetch_ctrl.sv
src/inst_queue.sv
src/fetch_top.sv
tests/tb_clock.sv
tests/bmem_model.sv
tests/fetch_tb.sv

//--- run.sh
#!/bin/sh
# build the fetch testbench with Verilator, run it, look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f sources.f --top-module fetch_tb -o fetch_sim &&
out="$(./obj_dir/fetch_sim)" &&
echo "$out" &&
echo "$out" | grep -qx "RESULT: PASS" && echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
